// ==== sb_params.svh ====
`ifndef SB_PARAMS_SVH
`define SB_PARAMS_SVH

// store buffer entries, kept a power of two so the pointers wrap on their own
`define SB_DEPTH 8

// data word width in bits
`define WORD_SIZE 32

// byte address width
`define ADDR_WIDTH 16

// reorder buffer entry id width
`define ROB_ID_WIDTH 5

// data memory depth in words, only the low address bits are decoded
`define MEM_WORDS 64

`endif

// ==== sb_pkg.sv ====
`default_nettype none

`include "sb_params.svh"

package sb_pkg;

	typedef enum logic {
		SIZE_BYTE = 1'b0, // single byte, any address
		SIZE_WORD = 1'b1  // aligned word
	} access_size_t;

	typedef logic [`WORD_SIZE-1:0] word_t;

	typedef logic [`ADDR_WIDTH-1:0] addr_t;

	typedef logic [`ROB_ID_WIDTH-1:0] rob_id_t;

endpackage

`default_nettype wire

// ==== store_queue.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "sb_params.svh"

module store_queue import sb_pkg::*; (
	input  wire                                clk,
	input  wire                                rst,
	input  wire                                store,
	input  word_t                              store_value,
	input  addr_t                              physical_address,
	input  rob_id_t                            input_rob_id,
	input  access_size_t                       op_size,
	input  wire                                tlb_exception,
	input  wire                                store_permission,
	input  rob_id_t                            store_permission_rob_id,
	input  wire                                store_success,
	output logic                               cache_wenable,
	output word_t                              cache_store_value,
	output addr_t                              cache_physical_address,
	output access_size_t                       cache_store_size,
	output logic                               full,
	output logic [`SB_DEPTH-1:0]               entry_valid,
	output addr_t [`SB_DEPTH-1:0]              entry_address,
	output word_t [`SB_DEPTH-1:0]              entry_value,
	output access_size_t [`SB_DEPTH-1:0]       entry_size,
	output logic [$clog2(`SB_DEPTH)-1:0]       head
);

	localparam int DEPTH = `SB_DEPTH;
	localparam int PTR_W = $clog2(`SB_DEPTH);

	rob_id_t [DEPTH-1:0] entry_rob; // rob id of each buffered store
	logic [DEPTH-1:0] entry_perm; // rob has released the entry

	logic [PTR_W-1:0] tail;
	logic [PTR_W:0] count; // one extra bit to hold DEPTH

	logic push;
	logic pop;

	logic perm_hit;
	logic [PTR_W-1:0] perm_idx;
	logic [PTR_W-1:0] perm_scan;

	assign push = store && !full && !tlb_exception; // faulting stores never enter
	assign pop = store_success;

	assign full = (count == (PTR_W+1)'(DEPTH));

	// head drains once the rob says it is no longer speculative
	assign cache_wenable = entry_valid[head] && entry_perm[head];
	assign cache_store_value = entry_value[head];
	assign cache_physical_address = entry_address[head];
	assign cache_store_size = entry_size[head];

	// oldest valid entry still waiting for this rob id
	always_comb begin
		perm_hit = 1'b0;
		perm_idx = head;
		perm_scan = head;
		for (int k = 0; k < DEPTH; k++) begin
			perm_scan = head + PTR_W'(k); // walk in age order
			if (!perm_hit && entry_valid[perm_scan] && !entry_perm[perm_scan] &&
				entry_rob[perm_scan] == store_permission_rob_id) begin
				perm_hit = store_permission;
				perm_idx = perm_scan;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			entry_valid <= '0;
			entry_perm <= '0;
			head <= '0;
			tail <= '0;
			count <= '0;
		end else begin
			if (perm_hit)
				entry_perm[perm_idx] <= 1'b1;

			if (pop) begin
				entry_valid[head] <= 1'b0;
				entry_perm[head] <= 1'b0;
				head <= head + 1'b1; // wraps with the pointer width
			end

			if (push) begin
				entry_valid[tail] <= 1'b1;
				entry_perm[tail] <= 1'b0; // tail slot is free so no clash with pop
				tail <= tail + 1'b1;
			end

			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// entry payload, written on insert
	always_ff @(posedge clk) begin
		if (push) begin
			entry_address[tail] <= physical_address;
			entry_value[tail] <= store_value;
			entry_size[tail] <= op_size;
			entry_rob[tail] <= input_rob_id;
		end
	end

	// an insert always lands in a free slot, so a full buffer takes none
	a_insert_free_slot: assert property (@(posedge clk) disable iff (rst)
		push |-> !entry_valid[tail]);

	// memory acks only a head entry the rob has released
	a_ack_on_head: assert property (@(posedge clk) disable iff (rst)
		store_success |-> entry_valid[head] && entry_perm[head]);

endmodule

`default_nettype wire

// ==== load_forward.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "sb_params.svh"

module load_forward import sb_pkg::*; (
	input  addr_t                              load_address,
	input  access_size_t                       load_size,
	input  wire [`SB_DEPTH-1:0]                entry_valid,
	input  addr_t [`SB_DEPTH-1:0]              entry_address,
	input  word_t [`SB_DEPTH-1:0]              entry_value,
	input  access_size_t [`SB_DEPTH-1:0]       entry_size,
	input  wire [$clog2(`SB_DEPTH)-1:0]        head,
	output word_t                              bypass_value,
	output logic                               bypass_needed,
	output logic                               bypass_possible
);

	localparam int DEPTH = `SB_DEPTH;
	localparam int PTR_W = $clog2(`SB_DEPTH);

	logic [PTR_W-1:0] idx;
	addr_t word_address; // load address with the byte offset cleared
	logic same_word;
	logic same_addr;
	logic [7:0] sel_byte;

	assign word_address = {load_address[`ADDR_WIDTH-1:2], 2'b00};

	// later iterations are younger stores, so the last hit wins
	always_comb begin
		bypass_value = '0;
		bypass_needed = 1'b0;
		bypass_possible = 1'b0;
		idx = head;
		same_word = 1'b0;
		same_addr = 1'b0;
		sel_byte = '0;
		for (int k = 0; k < DEPTH; k++) begin
			idx = head + PTR_W'(k);
			same_addr = (entry_address[idx] == load_address);
			same_word = (entry_address[idx][`ADDR_WIDTH-1:2] == load_address[`ADDR_WIDTH-1:2]);
			sel_byte = entry_value[idx][8*load_address[1:0] +: 8]; // lane of a word store
			if (entry_valid[idx]) begin
				if (load_size == SIZE_WORD) begin
					if (entry_size[idx] == SIZE_WORD && same_addr) begin
						bypass_value = entry_value[idx];
						bypass_needed = 1'b1;
						bypass_possible = 1'b1;
					end else if (entry_size[idx] == SIZE_BYTE && same_word) begin
						bypass_needed = 1'b1; // partial overlap
						bypass_possible = 1'b0;
					end
				end else begin
					if (entry_size[idx] == SIZE_BYTE && same_addr) begin
						bypass_value = {{(`WORD_SIZE-8){1'b0}}, entry_value[idx][7:0]};
						bypass_needed = 1'b1;
						bypass_possible = 1'b1;
					end else if (entry_size[idx] == SIZE_WORD &&
						entry_address[idx] == word_address) begin
						bypass_value = {{(`WORD_SIZE-8){1'b0}}, sel_byte}; // zero extended
						bypass_needed = 1'b1;
						bypass_possible = 1'b1;
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== data_mem.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "sb_params.svh"

module data_mem import sb_pkg::*; (
	input  wire          clk,
	input  wire          rst,
	input  wire          cache_wenable,
	input  addr_t        cache_physical_address,
	input  word_t        cache_store_value,
	input  access_size_t cache_store_size,
	output logic         store_success,
	input  addr_t        load_address,
	output word_t        mem_read_data
);

	localparam int IDX_W = $clog2(`MEM_WORDS);

	logic [3:0][7:0] mem [`MEM_WORDS]; // four byte lanes per word

	logic ack_q;
	logic do_write;
	logic [IDX_W-1:0] wr_idx;
	logic [1:0] wr_lane;
	logic [IDX_W-1:0] rd_idx;

	// a request seen during the ack cycle belongs to the store being popped
	assign do_write = cache_wenable && !ack_q;
	assign wr_idx = cache_physical_address[IDX_W+1:2];
	assign wr_lane = cache_physical_address[1:0];
	assign rd_idx = load_address[IDX_W+1:2];

	assign store_success = ack_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			ack_q <= 1'b0;
			for (int w = 0; w < `MEM_WORDS; w++)
				mem[w] <= '0;
		end else begin
			ack_q <= do_write; // one cycle pulse after each write
			if (do_write) begin
				if (cache_store_size == SIZE_WORD)
					mem[wr_idx] <= cache_store_value;
				else
					mem[wr_idx][wr_lane] <= cache_store_value[7:0]; // one lane only
			end
		end
	end

	// aligned word, the byte select happens in the stage
	assign mem_read_data = mem[rd_idx];

	// the request must stay up until its ack arrives
	a_wenable_held: assert property (@(posedge clk) disable iff (rst)
		cache_wenable && !store_success |=> cache_wenable);

endmodule

`default_nettype wire

// ==== mem_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "sb_params.svh"

module mem_stage import sb_pkg::*; (
	input  wire          clk,
	input  wire          rst,
	input  wire          store,
	input  word_t        store_value,
	input  addr_t        physical_address,
	input  rob_id_t      input_rob_id,
	input  access_size_t op_size,
	input  wire          tlb_exception,
	input  wire          store_permission,
	input  rob_id_t      store_permission_rob_id,
	input  wire          load,
	input  addr_t        load_address,
	input  access_size_t load_size,
	output logic         full,
	output word_t        load_data,
	output logic         load_valid,
	output logic         load_stall
);

	logic cache_wenable;
	word_t cache_store_value;
	addr_t cache_physical_address;
	access_size_t cache_store_size;
	logic store_success;

	logic [`SB_DEPTH-1:0] entry_valid;
	addr_t [`SB_DEPTH-1:0] entry_address;
	word_t [`SB_DEPTH-1:0] entry_value;
	access_size_t [`SB_DEPTH-1:0] entry_size;
	logic [$clog2(`SB_DEPTH)-1:0] head;

	word_t bypass_value;
	logic bypass_needed;
	logic bypass_possible;
	word_t mem_read_data;
	logic [7:0] mem_byte;

	store_queue u_store_queue (.clk, .rst, .store, .store_value, .physical_address,
		.input_rob_id, .op_size, .tlb_exception, .store_permission, .store_permission_rob_id,
		.store_success, .cache_wenable, .cache_store_value, .cache_physical_address,
		.cache_store_size, .full, .entry_valid, .entry_address, .entry_value, .entry_size,
		.head);

	load_forward u_load_forward (.load_address, .load_size, .entry_valid, .entry_address,
		.entry_value, .entry_size, .head, .bypass_value, .bypass_needed, .bypass_possible);

	data_mem u_data_mem (.clk, .rst, .cache_wenable, .cache_physical_address,
		.cache_store_value, .cache_store_size, .store_success, .load_address, .mem_read_data);

	assign mem_byte = mem_read_data[8*load_address[1:0] +: 8];

	assign load_stall = load && bypass_needed && !bypass_possible; // overlap it cannot serve
	assign load_valid = load && !load_stall;

	always_comb begin
		if (bypass_possible)
			load_data = bypass_value;
		else if (load_size == SIZE_WORD)
			load_data = mem_read_data;
		else
			load_data = {{(`WORD_SIZE-8){1'b0}}, mem_byte}; // zero extended byte load
	end

endmodule

`default_nettype wire

// ==== tb_mem_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "sb_params.svh"

module tb_mem_stage import sb_pkg::*; ();

	localparam int MB_W = $clog2(`MEM_WORDS) + 2; // byte index bits the memory decodes
	localparam int RANDOM_OPS = 300;
	localparam int SCHED_CYCLES = 16 + 150 + RANDOM_OPS + 60; // reset, directed, random, drain
	localparam int TIMEOUT_CYCLES = 3 * SCHED_CYCLES;

	typedef struct packed {
		addr_t addr;
		word_t val;
		access_size_t size;
		rob_id_t rob;
		logic perm;
	} pend_t;

	logic clk, rst;
	logic store, tlb_exception, store_permission, load;
	word_t store_value;
	addr_t physical_address, load_address;
	rob_id_t input_rob_id, store_permission_rob_id;
	access_size_t op_size, load_size;
	logic full, load_valid, load_stall;
	word_t load_data;

	pend_t pend[$]; // buffered stores, oldest first
	logic [7:0] ref_mem [2**MB_W];
	bit ref_ack;
	bit ref_write;
	word_t exp_data;
	bit exp_stall;
	int cycle_count = 0;
	int error_count = 0;
	integer seed;
	rob_id_t next_rob;

	mem_stage DUT (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, the store buffer never finished", cycle_count);
			stop_run();
		end
	end

	task automatic stop_run();
		error_count++;
		$display("ERRORS FOUND");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_word(input word_t got, input word_t exp, input string what);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
			stop_run();
		end
	endtask

	task automatic check_flag(input bit got, input bit exp, input string what);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s is %0b, expected %0b", $time, what, got, exp);
			stop_run();
		end
	endtask

	// model state moves on each edge from the inputs and state seen before it
	always @(posedge clk) begin
		if (rst) begin
			pend.delete();
			ref_ack = 1'b0;
			for (int i = 0; i < 2**MB_W; i++)
				ref_mem[i] = 8'h00;
		end else begin
			ref_write = !ref_ack && pend.size() > 0 && pend[0].perm;
			for (int i = 0; i < pend.size(); i++) begin
				if (store_permission && !pend[i].perm && pend[i].rob == store_permission_rob_id) begin
					pend[i].perm = 1'b1; // oldest waiting match only
					break;
				end
			end
			if (ref_write) begin
				if (pend[0].size == SIZE_BYTE)
					ref_mem[pend[0].addr[MB_W-1:0]] = pend[0].val[7:0];
				else
					for (int b = 0; b < 4; b++)
						ref_mem[{pend[0].addr[MB_W-1:2], 2'(b)}] = pend[0].val[8*b +: 8];
			end
			if (store && !tlb_exception && pend.size() < `SB_DEPTH) // full before the pop
				pend.push_back(pend_t'{addr: physical_address, val: store_value, size: op_size,
					rob: input_rob_id, perm: 1'b0});
			if (ref_ack)
				pend.delete(0); // popped on the ack edge
			ref_ack = ref_write;
		end
	end

	// youngest overlapping store decides, memory otherwise
	function automatic word_t expected_load(input addr_t addr, input access_size_t size,
		output bit stall);
		word_t value;
		bit needed;
		bit possible;
		value = '0;
		needed = 1'b0;
		possible = 1'b0;
		foreach (pend[i]) begin
			if (size == SIZE_WORD && pend[i].addr[`ADDR_WIDTH-1:2] == addr[`ADDR_WIDTH-1:2]) begin
				needed = 1'b1;
				possible = (pend[i].size == SIZE_WORD); // a byte store cannot fill a word
				if (possible)
					value = pend[i].val;
			end else if (size == SIZE_BYTE && pend[i].size == SIZE_BYTE && pend[i].addr == addr) begin
				needed = 1'b1;
				possible = 1'b1;
				value = word_t'(pend[i].val[7:0]);
			end else if (size == SIZE_BYTE && pend[i].size == SIZE_WORD &&
				pend[i].addr == {addr[`ADDR_WIDTH-1:2], 2'b00}) begin
				needed = 1'b1;
				possible = 1'b1;
				value = word_t'(pend[i].val[8*addr[1:0] +: 8]);
			end
		end
		stall = needed && !possible;
		if (possible)
			return value;
		if (size == SIZE_WORD)
			return {ref_mem[{addr[MB_W-1:2], 2'd3}], ref_mem[{addr[MB_W-1:2], 2'd2}],
				ref_mem[{addr[MB_W-1:2], 2'd1}], ref_mem[{addr[MB_W-1:2], 2'd0}]};
		return word_t'(ref_mem[addr[MB_W-1:0]]);
	endfunction

	// outputs are settled half a cycle after the edge
	always @(negedge clk) begin
		if (!rst) begin
			check_flag(full, pend.size() == `SB_DEPTH, "full");
			exp_data = expected_load(load_address, load_size, exp_stall);
			check_flag(load_stall, load && exp_stall, "load_stall");
			check_flag(load_valid, load && !exp_stall, "load_valid");
			if (load && !exp_stall)
				check_word(load_data, exp_data, "load_data");
		end
	end

	task automatic next_cycle();
		@(posedge clk);
		#2;
		store = 1'b0;
		tlb_exception = 1'b0;
		store_permission = 1'b0;
		load = 1'b0;
	endtask

	task automatic put_store(input addr_t addr, input word_t val, input access_size_t size,
		input bit exc);
		store = 1'b1;
		physical_address = addr;
		store_value = val;
		op_size = size;
		input_rob_id = next_rob;
		tlb_exception = exc;
		next_rob = next_rob + 1'b1;
	endtask

	task automatic read_at(input addr_t addr, input access_size_t size);
		load = 1'b1;
		load_address = addr;
		load_size = size;
	endtask

	function automatic addr_t pick_addr(input access_size_t size);
		addr_t a;
		a = 16'h0040 + addr_t'($random(seed) & 31); // narrow window, lots of overlap
		if (size == SIZE_WORD)
			a[1:0] = 2'b00;
		return a;
	endfunction

	// releases the oldest waiting store each cycle until the buffer is empty
	task automatic drain_all();
		while (DUT.entry_valid != '0) begin
			for (int i = pend.size() - 1; i >= 0; i--) begin
				if (!pend[i].perm) begin
					store_permission = 1'b1;
					store_permission_rob_id = pend[i].rob;
				end
			end
			next_cycle();
		end
		if (pend.size() != 0) begin
			$display("The DUT buffer emptied while the model still holds %0d stores", pend.size());
			stop_run();
		end
	endtask

	initial begin
		logic [31:0] rnd;
		access_size_t sz;
		seed = 29;
		next_rob = '0;
		rst = 1'b1;
		store = 1'b0;
		store_value = '0;
		physical_address = '0;
		input_rob_id = '0;
		op_size = SIZE_WORD;
		tlb_exception = 1'b0;
		store_permission = 1'b0;
		store_permission_rob_id = '0;
		load = 1'b0;
		load_address = '0;
		load_size = SIZE_WORD;
		repeat (16) @(posedge clk);
		#2;
		rst = 1'b0;

		// fill with no permission, store 3 faults and the last two meet a full buffer
		for (int i = 0; i < `SB_DEPTH + 3; i++) begin
			sz = (i % 4 == 3) ? SIZE_BYTE : SIZE_WORD;
			put_store(addr_t'(16'h40 + 4 * (i % 3) + (sz == SIZE_BYTE ? 1 : 0)),
				word_t'(32'h0101_0101 * (i + 1)), sz, i == 3);
			read_at(16'h0044, SIZE_WORD);
			next_cycle();
		end
		// grants in reverse, so the head is released last
		for (int r = `SB_DEPTH + 2; r >= 0; r--) begin
			store_permission = 1'b1;
			store_permission_rob_id = rob_id_t'(r);
			read_at(16'h0040, SIZE_WORD);
			next_cycle();
		end
		drain_all();
		for (int a = 0; a < 12; a++) begin
			read_at(addr_t'(16'h40 + a), (a % 4 == 0) ? SIZE_WORD : SIZE_BYTE);
			next_cycle();
		end

		put_store(16'h0060, 32'hCAFE_0001, SIZE_WORD, 1'b0);
		next_cycle();
		read_at(16'h0060, SIZE_WORD);
		put_store(16'h0060, 32'hCAFE_0002, SIZE_WORD, 1'b0); // load still sees the older one
		next_cycle();
		read_at(16'h0060, SIZE_WORD);
		put_store(16'h0064, 32'hA1B2_C3D4, SIZE_WORD, 1'b0);
		next_cycle();
		for (int off = 0; off < 4; off++) begin
			read_at(addr_t'(16'h64 + off), SIZE_BYTE);
			next_cycle();
		end
		drain_all();

		put_store(16'h0069, 32'h0000_005A, SIZE_BYTE, 1'b0);
		next_cycle();
		read_at(16'h0068, SIZE_WORD); // held until the byte store leaves
		store_permission = 1'b1;
		store_permission_rob_id = next_rob - 1'b1;
		do
			@(negedge clk);
		while (load_stall);
		next_cycle();

		for (int n = 0; n < RANDOM_OPS; n++) begin
			rnd = $random(seed);
			sz = rnd[2] ? SIZE_WORD : SIZE_BYTE;
			if (rnd[1:0] != 2'b00)
				put_store(pick_addr(sz), $random(seed), sz, rnd[7:4] == 4'h0);
			if (rnd[9:8] != 2'b00) begin
				store_permission = 1'b1;
				store_permission_rob_id = next_rob - rob_id_t'(rnd[12:10]) - 1'b1;
			end
			if (rnd[13]) begin
				sz = rnd[14] ? SIZE_WORD : SIZE_BYTE;
				read_at(pick_addr(sz), sz);
			end
			next_cycle();
		end
		drain_all();
		for (int w = 0; w < 8; w++) begin
			read_at(addr_t'(16'h40 + 4 * w), SIZE_WORD);
			next_cycle();
		end

		if (error_count == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+.
sb_pkg.sv
store_queue.sv
load_forward.sv
data_mem.sv
mem_stage.sv
tb_mem_stage.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the memory stage testbench with Verilator, runs it and checks the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f verilog.f --top-module tb_mem_stage -o sim_mem_stage \
	&& ./obj_dir/sim_mem_stage > sim.log 2>&1 \
	|| echo "build or simulation exited with an error" >> sim.log
cat sim.log
! grep -q "ERRORS FOUND" sim.log && grep -q "NO ERRORS" sim.log \
	&& echo "simulation passed" || { echo "simulation failed"; exit 1; }
